/* include/ooo_consts.svh */
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

`define XLEN         32
`define REG_NUM      8
`define REG_ADDR_LEN 3
`define ROB_SIZE     8
`define ROB_TAG_LEN  3
`define RS_SIZE      4

// alu op codes
`define OP_LI  3'd0
`define OP_ADD 3'd1
`define OP_SUB 3'd2
`define OP_AND 3'd3
`define OP_XOR 3'd4

`endif

/* verilog/ooo_pkg.sv */
`include "ooo_consts.svh"

package ooo_pkg;

   typedef struct packed {
      logic [2:0]                 op;
      logic [`REG_ADDR_LEN-1:0]   dest;
      logic [`REG_ADDR_LEN-1:0]   src1;
      logic [`REG_ADDR_LEN-1:0]   src2;
      logic [`XLEN-1:0]           imm;
   } dispatch_insn_t;

   // rename state of one architectural register
   typedef struct packed {
      logic                       busy;
      logic                       result_ready; // producer has broadcast, value sits in rob
      logic [`ROB_TAG_LEN-1:0]    rob_tag;
   } src_state_t;

   typedef struct packed {
      logic                       ready;
      logic [`ROB_TAG_LEN-1:0]    tag;   // producer tag while not ready
      logic [`XLEN-1:0]           value;
   } src_operand_t;

   typedef struct packed {
      logic [2:0]                 op;
      logic [`ROB_TAG_LEN-1:0]    tag_dest;
      src_operand_t               src1;
      src_operand_t               src2;
   } rs_entry_t;

   typedef struct packed {
      logic [`REG_ADDR_LEN-1:0]   dest;
      logic [`ROB_TAG_LEN-1:0]    tag;
   } rob_alloc_t;

   typedef struct packed {
      logic [2:0]                 op;
      logic [`ROB_TAG_LEN-1:0]    tag_dest;
      logic [`XLEN-1:0]           value1;
      logic [`XLEN-1:0]           value2;
   } issue_t;

   typedef struct packed {
      logic                       valid;
      logic [`ROB_TAG_LEN-1:0]    tag;
      logic [`XLEN-1:0]           value;
   } cdb_t;

   typedef struct packed {
      logic                       valid;
      logic [`REG_ADDR_LEN-1:0]   dest;
      logic [`ROB_TAG_LEN-1:0]    tag;
      logic [`XLEN-1:0]           value;
   } commit_t;

endpackage

/* verilog/map_table.sv */
`timescale 1ns/1ps
`include "ooo_consts.svh"

module map_table (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      rename_valid,
   input  logic [`REG_ADDR_LEN-1:0]  rename_dest,
   input  logic [`ROB_TAG_LEN-1:0]   rename_tag,
   input  logic [`REG_ADDR_LEN-1:0]  src1_addr,
   input  logic [`REG_ADDR_LEN-1:0]  src2_addr,
   output ooo_pkg::src_state_t       src1_state,
   output ooo_pkg::src_state_t       src2_state,
   input  ooo_pkg::cdb_t             cdb,
   input  ooo_pkg::commit_t          commit
);
   import ooo_pkg::*;

   src_state_t map [`REG_NUM];

   assign src1_state = map[src1_addr];
   assign src2_state = map[src2_addr];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `REG_NUM; i++) begin
            map[i] <= '0;
         end
      end else begin
         // r0 is skipped, it never gets renamed
         for (int i = 1; i < `REG_NUM; i++) begin
            if (cdb.valid && map[i].busy && map[i].rob_tag == cdb.tag) begin
               map[i].result_ready <= 1'b1;
            end
         end
         // only the latest producer may release the register
         if (commit.valid && map[commit.dest].busy && map[commit.dest].rob_tag == commit.tag) begin
            map[commit.dest].busy <= 1'b0;
         end
         if (rename_valid && rename_dest != '0) begin // newer rename overrides commit
            map[rename_dest].busy         <= 1'b1;
            map[rename_dest].result_ready <= 1'b0;
            map[rename_dest].rob_tag      <= rename_tag;
         end
      end
   end

   r0_never_busy: assert property (@(posedge clk) disable iff (reset) !map[0].busy);

endmodule

/* verilog/arch_regfile.sv */
`timescale 1ns/1ps
`include "ooo_consts.svh"

module arch_regfile (
   input  logic                      clk,
   input  logic                      reset,
   input  ooo_pkg::commit_t          commit,
   input  logic [`REG_ADDR_LEN-1:0]  read_addr1,
   input  logic [`REG_ADDR_LEN-1:0]  read_addr2,
   output logic [`XLEN-1:0]          read_data1,
   output logic [`XLEN-1:0]          read_data2
);

   logic [`XLEN-1:0] regs [`REG_NUM];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `REG_NUM; i++) begin
            regs[i] <= '0;
         end
      end else if (commit.valid && commit.dest != '0) begin // r0 stays zero
         regs[commit.dest] <= commit.value;
      end
   end

   assign read_data1 = regs[read_addr1];
   assign read_data2 = regs[read_addr2];

endmodule

/* verilog/dispatcher.sv */
`timescale 1ns/1ps
`include "ooo_consts.svh"

module dispatcher (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      insn_req,
   input  ooo_pkg::dispatch_insn_t   insn,
   output logic                      insn_ack,
   input  ooo_pkg::src_state_t       src1_state,
   input  ooo_pkg::src_state_t       src2_state,
   output logic [`REG_ADDR_LEN-1:0]  reg_read_addr1,
   output logic [`REG_ADDR_LEN-1:0]  reg_read_addr2,
   input  logic [`XLEN-1:0]          reg_read_data1,
   input  logic [`XLEN-1:0]          reg_read_data2,
   output logic [`ROB_TAG_LEN-1:0]   rob_read_tag1,
   output logic [`ROB_TAG_LEN-1:0]   rob_read_tag2,
   input  logic [`XLEN-1:0]          rob_read_value1,
   input  logic [`XLEN-1:0]          rob_read_value2,
   input  logic [`ROB_TAG_LEN-1:0]   rob_tail_tag,
   input  logic                      rob_full,
   input  logic                      rs_full,
   output logic                      rename_valid,
   output logic [`REG_ADDR_LEN-1:0]  rename_dest,
   output logic [`ROB_TAG_LEN-1:0]   rename_tag,
   output logic                      rs_write,
   output ooo_pkg::rs_entry_t        rs_entry,
   output logic                      rob_write,
   output ooo_pkg::rob_alloc_t       rob_alloc
);
   import ooo_pkg::*;

   logic accept;

   // regfile, rob result or wait on the producer tag
   function automatic src_operand_t resolve(input src_state_t st,
                                            input logic [`XLEN-1:0] reg_value,
                                            input logic [`XLEN-1:0] rob_value);
      src_operand_t opnd;
      opnd.tag   = st.rob_tag;
      opnd.ready = !st.busy || st.result_ready;
      if (!st.busy)
         opnd.value = reg_value;
      else if (st.result_ready)
         opnd.value = rob_value;
      else
         opnd.value = '0;
      return opnd;
   endfunction

   assign accept = insn_req && !insn_ack && !rs_full && !rob_full;

   always_ff @(posedge clk) begin
      if (reset)
         insn_ack <= 1'b0;
      else if (accept)
         insn_ack <= 1'b1;
      else if (insn_ack && !insn_req) // requester has let go
         insn_ack <= 1'b0;
   end

   assign reg_read_addr1 = insn.src1;
   assign reg_read_addr2 = insn.src2;
   assign rob_read_tag1  = src1_state.rob_tag;
   assign rob_read_tag2  = src2_state.rob_tag;

   assign rename_valid = accept;
   assign rename_dest  = insn.dest;
   assign rename_tag   = rob_tail_tag;

   always_comb begin
      rs_entry.op       = insn.op;
      rs_entry.tag_dest = rob_tail_tag;
      if (insn.op == `OP_LI) begin // immediate rides in src1
         rs_entry.src1 = '{ready: 1'b1, tag: '0, value: insn.imm};
         rs_entry.src2 = '{ready: 1'b1, tag: '0, value: '0};
      end else begin
         rs_entry.src1 = resolve(src1_state, reg_read_data1, rob_read_value1);
         rs_entry.src2 = resolve(src2_state, reg_read_data2, rob_read_value2);
      end
   end

   assign rs_write       = accept;
   assign rob_write      = accept;
   assign rob_alloc.dest = insn.dest;
   assign rob_alloc.tag  = rob_tail_tag;

endmodule

/* verilog/reservation_station.sv */
`timescale 1ns/1ps
`include "ooo_consts.svh"

module reservation_station (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 rs_write,
   input  ooo_pkg::rs_entry_t   rs_entry,
   output logic                 rs_full,
   input  ooo_pkg::cdb_t        cdb,
   output logic                 issue_req,
   output ooo_pkg::issue_t      issue,
   input  logic                 issue_ack
);
   import ooo_pkg::*;

   localparam int SLOT_W = $clog2(`RS_SIZE);

   rs_entry_t                entry [`RS_SIZE];
   logic [`RS_SIZE-1:0]      valid;
   logic [`RS_SIZE-1:0]      older [`RS_SIZE]; // older[i][j] set when i came before j
   logic [`RS_SIZE-1:0]      ready_vec;
   logic [`RS_SIZE-1:0]      oldest;
   logic [SLOT_W-1:0]        free_slot;
   logic [SLOT_W-1:0]        sel_slot;
   logic [SLOT_W-1:0]        issue_slot;
   logic                     sel_valid;

   // pick up a matching broadcast
   function automatic src_operand_t wake(input src_operand_t opnd, input cdb_t bus);
      src_operand_t res;
      res = opnd;
      if (!opnd.ready && bus.valid && bus.tag == opnd.tag) begin
         res.ready = 1'b1;
         res.value = bus.value;
      end
      return res;
   endfunction

   assign rs_full = &valid;

   always_comb begin
      free_slot = '0;
      sel_slot  = '0;
      for (int i = `RS_SIZE - 1; i >= 0; i--) begin
         if (!valid[i])
            free_slot = SLOT_W'(i); // lowest empty slot
      end
      for (int i = 0; i < `RS_SIZE; i++) begin
         ready_vec[i] = valid[i] && entry[i].src1.ready && entry[i].src2.ready;
      end
      for (int i = 0; i < `RS_SIZE; i++) begin
         oldest[i] = ready_vec[i];
         for (int j = 0; j < `RS_SIZE; j++) begin
            if (j != i && ready_vec[j] && older[j][i])
               oldest[i] = 1'b0;
         end
         if (oldest[i])
            sel_slot = SLOT_W'(i);
      end
      sel_valid = |ready_vec;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         valid     <= '0;
         issue_req <= 1'b0;
      end else begin
         for (int i = 0; i < `RS_SIZE; i++) begin
            if (valid[i]) begin
               entry[i].src1 <= wake(entry[i].src1, cdb);
               entry[i].src2 <= wake(entry[i].src2, cdb);
            end
         end
         if (issue_req && issue_ack) begin
            issue_req         <= 1'b0;
            valid[issue_slot] <= 1'b0;
         end else if (!issue_req && !issue_ack && sel_valid) begin // alu idle
            issue_req      <= 1'b1;
            issue_slot     <= sel_slot;
            issue.op       <= entry[sel_slot].op;
            issue.tag_dest <= entry[sel_slot].tag_dest;
            issue.value1   <= entry[sel_slot].src1.value;
            issue.value2   <= entry[sel_slot].src2.value;
         end
         if (rs_write) begin
            entry[free_slot].op       <= rs_entry.op;
            entry[free_slot].tag_dest <= rs_entry.tag_dest;
            entry[free_slot].src1     <= wake(rs_entry.src1, cdb);
            entry[free_slot].src2     <= wake(rs_entry.src2, cdb);
            valid[free_slot]          <= 1'b1;
            for (int j = 0; j < `RS_SIZE; j++) begin
               older[free_slot][j] <= 1'b0; // new entry is youngest
               if (j != free_slot)
                  older[j][free_slot] <= 1'b1;
            end
         end
      end
   end

   issue_stable: assert property (@(posedge clk) disable iff (reset)
      issue_req && !issue_ack |=> $stable(issue));

endmodule

/* verilog/alu_unit.sv */
`timescale 1ns/1ps
`include "ooo_consts.svh"

module alu_unit (
   input  logic              clk,
   input  logic              reset,
   input  logic              issue_req,
   input  ooo_pkg::issue_t   issue,
   output logic              issue_ack,
   output ooo_pkg::cdb_t     cdb
);

   logic [`XLEN-1:0] result;

   always_comb begin
      case (issue.op)
         `OP_LI:  result = issue.value1;
         `OP_ADD: result = issue.value1 + issue.value2;
         `OP_SUB: result = issue.value1 - issue.value2;
         `OP_AND: result = issue.value1 & issue.value2;
         `OP_XOR: result = issue.value1 ^ issue.value2;
         default: result = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         issue_ack <= 1'b0;
         cdb.valid <= 1'b0;
      end else begin
         cdb.valid <= 1'b0; // single cycle broadcast
         if (issue_req && !issue_ack) begin
            issue_ack <= 1'b1;
            cdb.valid <= 1'b1;
            cdb.tag   <= issue.tag_dest;
            cdb.value <= result;
         end else if (!issue_req && issue_ack) begin
            issue_ack <= 1'b0;
         end
      end
   end

endmodule

/* verilog/reorder_buffer.sv */
`timescale 1ns/1ps
`include "ooo_consts.svh"

module reorder_buffer (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      rob_write,
   input  ooo_pkg::rob_alloc_t       rob_alloc,
   output logic [`ROB_TAG_LEN-1:0]   rob_tail_tag,
   output logic                      rob_full,
   input  ooo_pkg::cdb_t             cdb,
   input  logic [`ROB_TAG_LEN-1:0]   rob_read_tag1,
   input  logic [`ROB_TAG_LEN-1:0]   rob_read_tag2,
   output logic [`XLEN-1:0]          rob_read_value1,
   output logic [`XLEN-1:0]          rob_read_value2,
   output ooo_pkg::commit_t          commit
);

   logic [`REG_ADDR_LEN-1:0]  dest  [`ROB_SIZE];
   logic [`XLEN-1:0]          value [`ROB_SIZE];
   logic [`ROB_SIZE-1:0]      done;
   logic [`ROB_TAG_LEN-1:0]   head;
   logic [`ROB_TAG_LEN-1:0]   tail;
   logic [`ROB_TAG_LEN:0]     count;
   logic                      retire;

   assign retire       = (count != '0) && done[head];
   assign rob_full     = (count == `ROB_SIZE);
   assign rob_tail_tag = tail;

   // forwarding for results that have not committed yet
   assign rob_read_value1 = value[rob_read_tag1];
   assign rob_read_value2 = value[rob_read_tag2];

   always_ff @(posedge clk) begin
      if (reset) begin
         head         <= '0;
         tail         <= '0;
         count        <= '0;
         done         <= '0;
         commit.valid <= 1'b0;
      end else begin
         commit.valid <= retire;
         if (retire) begin
            commit.dest  <= dest[head];
            commit.tag   <= head;
            commit.value <= value[head];
            done[head]   <= 1'b0;
            head         <= head + 1'b1; // wraps with the tag width
         end
         if (cdb.valid) begin
            done[cdb.tag]  <= 1'b1;
            value[cdb.tag] <= cdb.value;
         end
         if (rob_write) begin
            dest[rob_alloc.tag] <= rob_alloc.dest;
            done[rob_alloc.tag] <= 1'b0;
            tail                <= tail + 1'b1;
         end
         case ({rob_write, retire})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   no_write_when_full: assert property (@(posedge clk) disable iff (reset)
      rob_full |-> !rob_write);

endmodule

/* verilog/ooo_dispatch_top.sv */
`timescale 1ns/1ps
`include "ooo_consts.svh"

module ooo_dispatch_top (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      insn_req,
   input  ooo_pkg::dispatch_insn_t   insn,
   output logic                      insn_ack,
   output ooo_pkg::commit_t          commit
);
   import ooo_pkg::*;

   src_state_t                src1_state, src2_state;
   logic [`REG_ADDR_LEN-1:0]  reg_read_addr1, reg_read_addr2;
   logic [`XLEN-1:0]          reg_read_data1, reg_read_data2;
   logic [`ROB_TAG_LEN-1:0]   rob_read_tag1, rob_read_tag2;
   logic [`XLEN-1:0]          rob_read_value1, rob_read_value2;
   logic [`ROB_TAG_LEN-1:0]   rob_tail_tag;
   logic                      rob_full, rs_full;
   logic                      rename_valid;
   logic [`REG_ADDR_LEN-1:0]  rename_dest;
   logic [`ROB_TAG_LEN-1:0]   rename_tag;
   logic                      rs_write, rob_write;
   rs_entry_t                 rs_entry;
   rob_alloc_t                rob_alloc;
   logic                      issue_req, issue_ack;
   issue_t                    issue;
   cdb_t                      cdb;

   map_table i_map_table (
      .clk, .reset, .rename_valid, .rename_dest, .rename_tag,
      .src1_addr (insn.src1), .src2_addr (insn.src2),
      .src1_state, .src2_state, .cdb, .commit
   );

   arch_regfile i_arch_regfile (
      .clk, .reset, .commit,
      .read_addr1 (reg_read_addr1), .read_addr2 (reg_read_addr2),
      .read_data1 (reg_read_data1), .read_data2 (reg_read_data2)
   );

   dispatcher i_dispatcher (.*);

   reservation_station i_reservation_station (
      .clk, .reset, .rs_write, .rs_entry, .rs_full, .cdb,
      .issue_req, .issue, .issue_ack
   );

   alu_unit i_alu_unit (.clk, .reset, .issue_req, .issue, .issue_ack, .cdb);

   reorder_buffer i_reorder_buffer (
      .clk, .reset, .rob_write, .rob_alloc, .rob_tail_tag, .rob_full, .cdb,
      .rob_read_tag1, .rob_read_tag2, .rob_read_value1, .rob_read_value2, .commit
   );

endmodule

/* dv/ooo_dispatch_tb.sv */
`timescale 1ns/1ps
`include "ooo_consts.svh"

module ooo_dispatch_tb;
   import ooo_pkg::*;

   localparam int TIMEOUT = 400; // cycles allowed for any single wait

   typedef struct packed {
      logic [`REG_ADDR_LEN-1:0]  dest;
      logic [`ROB_TAG_LEN-1:0]   tag;
      logic [`XLEN-1:0]          value;
   } expect_t;

   logic             clk;
   logic             reset;
   logic             insn_req;
   dispatch_insn_t   insn;
   logic             insn_ack;
   commit_t          commit;

   logic [`XLEN-1:0]         gold [`REG_NUM]; // architectural state in program order
   logic [`ROB_TAG_LEN-1:0]  next_tag;        // rob allocates tags round robin from zero
   expect_t                  exp_q [$];
   int                       errors;
   int                       commits_seen;
   string                    test_name;

   ooo_dispatch_top i_ooo_dispatch_top (
      .clk, .reset, .insn_req, .insn, .insn_ack, .commit
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // every commit is checked against the oldest expectation
   always @(negedge clk) begin
      expect_t e;
      if (!reset && commit.valid) begin
         commits_seen++;
         if (exp_q.size() == 0) begin
            $display("%s: commit to r%0d arrived with nothing outstanding",
                     test_name, commit.dest);
            errors++;
         end else begin
            e = exp_q.pop_front();
            if (commit.dest != e.dest || commit.tag != e.tag || commit.value != e.value) begin
               $display("FAIL %s: expected r%0d tag %0d value %h, actual r%0d tag %0d value %h",
                        test_name, e.dest, e.tag, e.value,
                        commit.dest, commit.tag, commit.value);
               errors++;
            end
         end
      end
   end

   function automatic logic [`XLEN-1:0] model_result(input dispatch_insn_t in);
      logic [`XLEN-1:0] a;
      logic [`XLEN-1:0] b;
      a = gold[in.src1];
      b = gold[in.src2];
      case (in.op)
         `OP_ADD: return a + b;
         `OP_SUB: return a - b;
         `OP_AND: return a & b;
         `OP_XOR: return a ^ b;
         default: return in.imm; // li
      endcase
   endfunction

   task automatic abort_run(input string what);
      $display("%s: timed out waiting for %s", test_name, what);
      errors++;
      $display("errors: %0d, commits checked: %0d", errors, commits_seen);
      $display("SIMULATION FAILED");
      $finish;
   endtask

   // four-phase transfer of one instruction, model updated in program order
   task automatic send_insn(input logic [2:0] op, input int dest, input int src1,
                            input int src2, input logic [`XLEN-1:0] imm);
      dispatch_insn_t in;
      expect_t        e;
      int             cycles;
      in.op   = op;
      in.dest = dest[`REG_ADDR_LEN-1:0];
      in.src1 = src1[`REG_ADDR_LEN-1:0];
      in.src2 = src2[`REG_ADDR_LEN-1:0];
      in.imm  = imm;
      e.dest  = in.dest;
      e.tag   = next_tag;
      e.value = model_result(in);
      exp_q.push_back(e);
      if (in.dest != '0)
         gold[in.dest] = e.value; // r0 stays zero
      next_tag = next_tag + 1'b1;
      insn     = in;
      insn_req = 1'b1;
      cycles   = 0;
      while (!insn_ack && cycles < TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (!insn_ack)
         abort_run("insn_ack to rise");
      insn_req = 1'b0;
      cycles   = 0;
      while (insn_ack && cycles < TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (insn_ack)
         abort_run("insn_ack to fall");
   endtask

   // wait until no more than limit expectations are still open
   task automatic wait_outstanding(input int limit);
      int cycles;
      int pending;
      while (exp_q.size() > limit) begin
         pending = exp_q.size();
         cycles  = 0;
         while (exp_q.size() == pending && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
         end
         if (exp_q.size() == pending)
            abort_run("a commit");
      end
   endtask

   task automatic drain_commits();
      wait_outstanding(0);
   endtask

   task automatic test_reset();
      test_name = "test_reset";
      repeat (6) begin
         @(negedge clk);
         if (insn_ack !== 1'b0) begin
            $display("FAIL %s: insn_ack expected 0, actual %b", test_name, insn_ack);
            errors++;
         end
         if (commit.valid !== 1'b0) begin
            $display("FAIL %s: commit.valid expected 0, actual %b", test_name, commit.valid);
            errors++;
         end
      end
   endtask

   task automatic test_independent();
      test_name = "test_independent";
      for (int r = 1; r < `REG_NUM; r++) begin
         send_insn(`OP_LI, r, 0, 0, 32'ha5a5_0000 + 32'(r) * 32'h0001_0203);
      end
      send_insn(`OP_ADD, 1, 2, 3, '0);
      send_insn(`OP_SUB, 4, 5, 6, '0);
      send_insn(`OP_AND, 7, 2, 6, '0);
      send_insn(`OP_XOR, 5, 6, 2, '0); // war on r5 only
      drain_commits();
   endtask

   task automatic test_dependent_chain();
      test_name = "test_dependent_chain";
      send_insn(`OP_LI, 1, 0, 0, 32'h1234_5678);
      send_insn(`OP_ADD, 2, 1, 1, '0);
      send_insn(`OP_SUB, 3, 2, 1, '0);
      send_insn(`OP_XOR, 4, 3, 2, '0);
      send_insn(`OP_AND, 5, 4, 3, '0);
      send_insn(`OP_ADD, 6, 5, 3, '0);
      for (int n = 0; n < 10; n++) begin
         send_insn(`OP_ADD, 1, 1, 6, '0); // each one waits on the last
      end
      drain_commits();
   endtask

   task automatic test_r0();
      test_name = "test_r0";
      send_insn(`OP_LI, 0, 0, 0, 32'hdead_beef);
      send_insn(`OP_ADD, 1, 0, 0, '0);
      send_insn(`OP_LI, 2, 0, 0, 32'd55);
      send_insn(`OP_XOR, 3, 2, 0, '0);
      send_insn(`OP_ADD, 0, 2, 2, '0);
      send_insn(`OP_ADD, 4, 0, 2, '0);
      drain_commits();
   endtask

   task automatic test_waw();
      test_name = "test_waw";
      send_insn(`OP_LI, 4, 0, 0, 32'd100);
      send_insn(`OP_LI, 4, 0, 0, 32'd200);
      send_insn(`OP_ADD, 5, 4, 4, '0);
      drain_commits();
      // older r4 write retires behind a chain while the newer one still waits on r3
      send_insn(`OP_LI, 2, 0, 0, 32'd3);
      send_insn(`OP_ADD, 2, 2, 2, '0);
      send_insn(`OP_ADD, 2, 2, 2, '0);
      send_insn(`OP_ADD, 2, 2, 2, '0);
      send_insn(`OP_LI, 4, 0, 0, 32'd7);
      send_insn(`OP_ADD, 3, 2, 2, '0);
      send_insn(`OP_SUB, 4, 3, 5, '0);
      wait_outstanding(2); // older r4 write has committed
      @(negedge clk);
      send_insn(`OP_XOR, 6, 4, 2, '0);
      drain_commits();
      send_insn(`OP_ADD, 7, 4, 0, '0);
      drain_commits();
   endtask

   task automatic test_random_burst();
      int         start;
      int         op_sel;
      logic [2:0] op;
      test_name = "test_random_burst";
      start     = commits_seen;
      for (int n = 0; n < 40; n++) begin
         op_sel = $urandom_range(4, 0);
         op     = op_sel[2:0];
         send_insn(op, $urandom_range(7, 0), $urandom_range(7, 0), $urandom_range(7, 0),
                   $urandom());
      end
      drain_commits();
      if (commits_seen - start != 40) begin
         $display("FAIL %s: expected 40 commits, actual %0d", test_name, commits_seen - start);
         errors++;
      end
   endtask

   initial begin
      void'($urandom(19));
      reset        = 1'b1;
      insn_req     = 1'b0;
      insn         = '0;
      errors       = 0;
      commits_seen = 0;
      next_tag     = '0;
      test_name    = "reset";
      for (int r = 0; r < `REG_NUM; r++) begin
         gold[r] = '0;
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      test_reset();
      test_independent();
      test_dependent_chain();
      test_r0();
      test_waw();
      test_random_burst();
      $display("errors: %0d, commits checked: %0d", errors, commits_seen);
      if (errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

/* compile.f */
+incdir+include
verilog/ooo_pkg.sv
verilog/map_table.sv
verilog/arch_regfile.sv
verilog/dispatcher.sv
verilog/reservation_station.sv
verilog/alu_unit.sv
verilog/reorder_buffer.sv
verilog/ooo_dispatch_top.sv
dv/ooo_dispatch_tb.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f compile.f --top-module ooo_dispatch_tb -o ooo_sim

sim_out=$(./obj_dir/ooo_sim) || true
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -q "SIMULATION PASSED"
